// File: hdl/fetch_defines.svh
/*
 * shared constants of the instruction fetch stage.
 * included by the package, the RTL modules and the testbench.
 */
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// width of an address and of an instruction word.
`define FETCH_XLEN 32

// the first address fetched after reset_n or sys_reset.
`define FETCH_START_ADDR 32'h0000_1000

// the queue holds two words, enough to cover one cycle of memory latency.
`define FETCH_IQ_DEPTH 2
`define FETCH_IQ_AWIDTH 1   // log2 of the depth.

// addi x0, x0, 0 is shown toward decode until the first word is fetched.
`define FETCH_NOP 32'h0000_0013

`endif

// File: hdl/fetch_pkg.sv
/*
 * types shared by the fetch RTL and its testbench.
 * every module takes them with a wildcard import of fetch_pkg.
 */
`include "fetch_defines.svh"

package fetch_pkg;

    // one address or one instruction.
    typedef logic [`FETCH_XLEN-1:0] word_t;

    // read request toward the instruction memory.
    typedef struct packed {
        logic  en;     // a read is wanted this cycle.
        word_t addr;   // word aligned.
    } imem_req_t;

    // redirect command coming back from the execute stage.
    typedef struct packed {
        logic  jump;         // one cycle strobe.
        logic  ctx_switch;   // one cycle strobe, wins over jump.
        word_t jump_target;
        word_t ctx_target;
    } redirect_t;

    // the word handed to decode together with its address.
    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instruction;
    } fetch_out_t;

endpackage

// File: hdl/instr_queue.sv
/*
 * circular instruction queue between the memory reply and decode.
 * it keeps words that were already requested while decode is stalled.
 * a flush empties it in one cycle. DEPTH is a power of two of 2 or more.
 */
`include "fetch_defines.svh"

module instr_queue
    import fetch_pkg::*;
#(
    parameter int DEPTH  = `FETCH_IQ_DEPTH,    // number of entries.
    parameter int AWIDTH = `FETCH_IQ_AWIDTH    // pointer width, log2 of DEPTH.
) (
    input  logic  clk,
    input  logic  reset_n,
    input  logic  flush_i,          // drops every stored word.
    input  logic  push_i,
    input  word_t data_i,
    input  logic  pop_i,
    output word_t data_o,           // head of the queue.
    output logic  occupied_o,       // at least one word is stored.
    output logic  full_o,
    output logic  almost_full_o     // at most one free entry is left.
);
    // count value of a full queue, sized like the counter.
    localparam logic [AWIDTH:0] FULL_COUNT = (AWIDTH + 1)'(DEPTH);

    if (((1 << AWIDTH) != DEPTH) || (DEPTH < 2)) begin : g_depth_check
        $error("instr_queue needs DEPTH equal to 2**AWIDTH and at least 2.");
    end

    word_t             mem [DEPTH];
    logic [AWIDTH-1:0] rd_ptr;      // entry returned on data_o.
    logic [AWIDTH-1:0] wr_ptr;      // entry written by the next push.
    logic [AWIDTH:0]   count;       // one bit wider than the pointers so full and empty differ.

    // the pointers wrap by themselves because DEPTH is a power of two.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (flush_i) begin
            rd_ptr <= '0;   // a flush also recentres the pointers.
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop_i)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // a push with a pop leaves the count alone.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push_i && !flush_i)
            mem[wr_ptr] <= data_i;
    end

    assign data_o        = mem[rd_ptr];
    assign occupied_o    = (count != '0);
    assign full_o        = (count == FULL_COUNT);
    assign almost_full_o = (count >= FULL_COUNT - 1'b1);   // request side throttles on this.

    // the request side only lets a reply come back when there is room for it.
    a_no_overflow: assert property (@(posedge clk) disable iff (!reset_n)
        (push_i && !flush_i) |-> (!full_o || pop_i))
        else $error("instr_queue push while full");

    // decode is fed from the memory reply while the queue is empty.
    a_no_underflow: assert property (@(posedge clk) disable iff (!reset_n)
        (pop_i && !flush_i) |-> occupied_o)
        else $error("instr_queue pop while empty");

endmodule

// File: hdl/fetch_request.sv
/*
 * request side of the fetch stage.
 * owns the instruction address and the memory request, qualifies each reply
 * and sends it into the queue or straight on to decode. redirects land here.
 */
`include "fetch_defines.svh"

module fetch_request
    import fetch_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  logic      sys_reset_i,       // synchronous restart.
    input  logic      enable_i,          // decode takes a word this cycle.
    input  logic      busy_i,            // memory cannot accept a request.
    input  redirect_t redirect_i,
    input  logic      jump_pending_i,    // output side still waits for the target word.
    input  word_t     imem_data_i,       // reply to last cycle's accepted request.
    input  word_t     iq_data_i,         // head of the queue.
    input  logic      occupied_i,
    input  logic      full_i,
    input  logic      almost_full_i,
    output imem_req_t imem_req_o,
    output logic      push_o,
    output logic      pop_o,
    output logic      flush_o,
    output word_t     iq_data_o,         // word written by a push.
    output word_t     next_instr_o,
    output logic      next_valid_o,
    output logic      redirect_taken_o,
    output word_t     redirect_target_o
);
    word_t iaddr;          // address of the word requested this cycle.
    logic  busy_r;         // set when no request was accepted last cycle.
    logic  stale_r;        // the reply now arriving was asked for before a redirect.
    logic  hold_r;         // requests wait one cycle after any reset.
    logic  reply_valid;
    logic  pass_through;
    logic  req_accepted;

    // a redirect during sys_reset is lost, the restart wins.
    assign redirect_taken_o  = (redirect_i.jump || redirect_i.ctx_switch) && !sys_reset_i;
    assign redirect_target_o = redirect_i.ctx_switch ? redirect_i.ctx_target
                                                     : redirect_i.jump_target;
    assign flush_o = redirect_taken_o || sys_reset_i;   // old words never reach decode.

    // a reply counts only if memory took the request and no redirect came since.
    assign reply_valid = !busy_r && !stale_r;

    // the queue head is older than the reply, so it leaves first.
    assign pop_o        = enable_i && occupied_i;
    assign pass_through = enable_i && !occupied_i;   // decode takes the reply directly.
    assign push_o       = reply_valid && !pass_through && !flush_o;
    assign iq_data_o    = imem_data_i;

    assign next_instr_o = occupied_i ? iq_data_i : imem_data_i;
    assign next_valid_o = occupied_i || reply_valid;

    // a request is made only when its reply will find room in the queue.
    // with a pop the count cannot grow, since a valid reply implies a free entry.
    always_comb begin
        imem_req_o.addr = iaddr;
        if (hold_r)
            imem_req_o.en = 1'b0;
        else if (pop_o)
            imem_req_o.en = 1'b1;
        else if (push_o)
            imem_req_o.en = !almost_full_i;   // this push takes one of the free entries.
        else
            imem_req_o.en = !full_i;
    end

    assign req_accepted = imem_req_o.en && !busy_i;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy_r  <= 1'b1;
            stale_r <= 1'b0;
            hold_r  <= 1'b1;
        end else if (sys_reset_i) begin
            busy_r  <= 1'b1;   // nothing was requested, so nothing comes back.
            stale_r <= 1'b0;
            hold_r  <= 1'b1;
        end else begin
            busy_r  <= !req_accepted;
            stale_r <= redirect_taken_o;   // drops the reply to this cycle's request.
            hold_r  <= 1'b0;
        end
    end

    // the address moves on only when memory took the request.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            iaddr <= `FETCH_START_ADDR;
        else if (sys_reset_i)
            iaddr <= `FETCH_START_ADDR;
        else if (redirect_taken_o)
            iaddr <= redirect_target_o;   // requested in the very next cycle.
        else if (req_accepted)
            iaddr <= iaddr + word_t'(4);
    end

    // the execute stage only hands over word aligned targets.
    a_iaddr_aligned: assert property (@(posedge clk) disable iff (!reset_n)
        imem_req_o.addr[1:0] == 2'b00)
        else $error("fetch_request misaligned request address %h", imem_req_o.addr);

    // after a redirect the output waits, and no old word is offered to it.
    a_redirect_drops_old: assert property (@(posedge clk) disable iff (!reset_n)
        redirect_taken_o |=> (jump_pending_i && !next_valid_o))
        else $error("fetch_request word from before a redirect offered to decode");

endmodule

// File: hdl/fetch_output.sv
/*
 * output side of the fetch stage.
 * registers pc, instruction and valid toward decode and tracks whether a
 * redirect still waits for its first word, which jumping_o shows.
 */
`include "fetch_defines.svh"

module fetch_output
    import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,
    input  logic       sys_reset_i,
    input  logic       enable_i,           // decode takes a word this cycle.
    input  word_t      next_instr_i,
    input  logic       next_valid_i,
    input  logic       redirect_taken_i,   // one cycle pulse from the request side.
    input  word_t      redirect_target_i,
    output fetch_out_t fetch_o,
    output logic       jumping_o,
    output logic       jump_pending_o
);
    word_t pc_saved;       // pc of the first word after a redirect or a reset.
    logic  jump_pending;   // that first word has not been taken yet.
    logic  accept;         // decode takes a valid word at this edge.

    assign accept = enable_i && next_valid_i;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            fetch_o.valid       <= 1'b0;
            fetch_o.pc          <= `FETCH_START_ADDR;
            fetch_o.instruction <= `FETCH_NOP;
        end else if (sys_reset_i) begin
            fetch_o.valid       <= 1'b0;
            fetch_o.pc          <= `FETCH_START_ADDR;
            fetch_o.instruction <= `FETCH_NOP;
        end else begin
            if (enable_i)
                fetch_o.valid <= next_valid_i;   // held while decode stalls.
            if (accept)
                fetch_o.instruction <= next_instr_i;
            // while pending the pc is pinned to the target, so the word taken
            // at the end of the wait carries it.
            if (jump_pending)
                fetch_o.pc <= pc_saved;
            else if (accept)
                fetch_o.pc <= fetch_o.pc + word_t'(4);
        end
    end

    // a reset behaves like a redirect to the start address.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc_saved     <= `FETCH_START_ADDR;
            jump_pending <= 1'b1;
        end else if (sys_reset_i) begin
            pc_saved     <= `FETCH_START_ADDR;
            jump_pending <= 1'b1;
        end else if (redirect_taken_i) begin
            pc_saved     <= redirect_target_i;
            jump_pending <= 1'b1;   // a new redirect restarts the wait.
        end else if (accept) begin
            jump_pending <= 1'b0;
        end
    end

    assign jumping_o      = jump_pending;
    assign jump_pending_o = jump_pending;

    // the pc comes either from a target or from a chain of +4 steps.
    a_pc_aligned: assert property (@(posedge clk) disable iff (!reset_n)
        fetch_o.pc[1:0] == 2'b00)
        else $error("fetch_output misaligned pc %h", fetch_o.pc);

endmodule

// File: hdl/fetch_top.sv
/*
 * top level of the instruction fetch stage.
 * connects the request side, the instruction queue and the output side.
 */
module fetch_top
    import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,
    input  logic       sys_reset_i,
    input  logic       enable_i,
    input  redirect_t  redirect_i,
    output imem_req_t  imem_req_o,
    input  logic       busy_i,
    input  word_t      imem_data_i,
    output fetch_out_t fetch_o,
    output logic       jumping_o
);
    // queue control and data.
    logic  push;
    logic  pop;
    logic  flush;
    word_t iq_wdata;
    word_t iq_rdata;
    logic  occupied;
    logic  full;
    logic  almost_full;

    // toward the output side and back.
    word_t next_instr;
    logic  next_valid;
    logic  redirect_taken;
    word_t redirect_target;
    logic  jump_pending;

    fetch_request u_request (
        .clk              (clk),
        .reset_n          (reset_n),
        .sys_reset_i      (sys_reset_i),
        .enable_i         (enable_i),
        .busy_i           (busy_i),
        .redirect_i       (redirect_i),
        .jump_pending_i   (jump_pending),
        .imem_data_i      (imem_data_i),
        .iq_data_i        (iq_rdata),
        .occupied_i       (occupied),
        .full_i           (full),
        .almost_full_i    (almost_full),
        .imem_req_o       (imem_req_o),
        .push_o           (push),
        .pop_o            (pop),
        .flush_o          (flush),
        .iq_data_o        (iq_wdata),
        .next_instr_o     (next_instr),
        .next_valid_o     (next_valid),
        .redirect_taken_o (redirect_taken),
        .redirect_target_o(redirect_target)
    );

    instr_queue u_queue (
        .clk          (clk),
        .reset_n      (reset_n),
        .flush_i      (flush),
        .push_i       (push),
        .data_i       (iq_wdata),
        .pop_i        (pop),
        .data_o       (iq_rdata),
        .occupied_o   (occupied),
        .full_o       (full),
        .almost_full_o(almost_full)
    );

    fetch_output u_output (
        .clk              (clk),
        .reset_n          (reset_n),
        .sys_reset_i      (sys_reset_i),
        .enable_i         (enable_i),
        .next_instr_i     (next_instr),
        .next_valid_i     (next_valid),
        .redirect_taken_i (redirect_taken),
        .redirect_target_i(redirect_target),
        .fetch_o          (fetch_o),
        .jumping_o        (jumping_o),
        .jump_pending_o   (jump_pending)
    );

endmodule

// File: bench/fetch_checker.sv
/*
 * checker of the fetch stage testbench. it watches the DUT ports, predicts
 * the word stream from the memory rule and the redirects it sees, and prints
 * one line per test when the bench marks the test as done.
 */
`include "fetch_defines.svh"

module fetch_checker
    import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,
    input  logic       sys_reset_i,
    input  logic       enable_i,
    input  logic       busy_i,
    input  redirect_t  redirect_i,
    input  imem_req_t  imem_req_i,
    input  fetch_out_t fetch_i,
    input  logic       jumping_i,
    input  int         test_id_i,
    input  logic       test_done_i,
    output int         errors_o,
    output int         failed_tests_o,
    output int         words_o
);
    timeunit 1ns;
    timeprecision 100ps;

    word_t      expected_pc = `FETCH_START_ADDR;   // pc of the next word decode takes.
    fetch_out_t held;                              // output seen at a stalled edge.
    logic       hold_armed     = 1'b0;
    logic       after_restart  = 1'b0;
    logic       after_redirect = 1'b0;
    logic       reset_seen     = 1'b0;   // reset was already low at an earlier edge.
    int         stall_reqs     = 0;   // requests accepted during the current stall.
    int         stale_words    = 0;   // old words taken since the last redirect.
    int         errors         = 0;
    int         failed_tests   = 0;
    int         words          = 0;
    int         test_errors    = 0;
    int         test_words     = 0;

    assign errors_o       = errors;
    assign failed_tests_o = failed_tests;
    assign words_o        = words;

    // the memory returns the address with its top byte replaced by A5.
    function automatic word_t expected_word(input word_t addr);
        return {8'hA5, addr[23:0]};
    endfunction

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("MISMATCH at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic failure(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        errors++;
        test_errors++;
    endtask

    task automatic check_reset_values();
        check_value("fetch_o.valid", 32'd0, word_t'(fetch_i.valid));
        check_value("fetch_o.pc", `FETCH_START_ADDR, fetch_i.pc);
        check_value("jumping_o", 32'd1, word_t'(jumping_i));
        check_value("imem_req_o.en", 32'd0, word_t'(imem_req_i.en));
        check_value("imem_req_o.addr", `FETCH_START_ADDR, imem_req_i.addr);
    endtask

    task automatic report_test();
        if (test_errors == 0) begin
            $display("test %0d passed, %0d words checked", test_id_i, test_words);
        end else begin
            $display("test %0d failed with %0d errors, %0d words checked",
                     test_id_i, test_errors, test_words);
            failed_tests++;
        end
        test_errors = 0;
        test_words  = 0;
    endtask

    // everything is sampled at the rising edge, before the DUT registers move.
    always @(posedge clk) begin
        if (!reset_n) begin
            if (reset_seen)
                check_reset_values();   // the DUT has taken the reset by the second low edge.
            reset_seen     = 1'b1;
            expected_pc    = `FETCH_START_ADDR;
            hold_armed     = 1'b0;
            after_restart  = 1'b0;
            after_redirect = 1'b0;
            stall_reqs     = 0;
            stale_words    = 0;
        end else begin
            if (after_restart) begin
                check_reset_values();
                check_value("fetch_o.instruction", `FETCH_NOP, fetch_i.instruction);
            end
            if (after_redirect) begin
                check_value("jumping_o", 32'd1, word_t'(jumping_i));
                check_value("imem_req_o.addr", expected_pc, imem_req_i.addr);
            end
            if (hold_armed) begin   // a stalled decode sees the same word again.
                check_value("fetch_o.valid", word_t'(held.valid), word_t'(fetch_i.valid));
                check_value("fetch_o.pc", held.pc, fetch_i.pc);
                check_value("fetch_o.instruction", held.instruction, fetch_i.instruction);
            end
            if (enable_i && fetch_i.valid) begin
                if (jumping_i) begin
                    stale_words++;   // at most the word already registered.
                    if (stale_words == 2)
                        failure("more than one old word reached decode after a redirect");
                end else begin
                    check_value("fetch_o.pc", expected_pc, fetch_i.pc);
                    check_value("fetch_o.instruction", expected_word(expected_pc),
                                fetch_i.instruction);
                    expected_pc = expected_pc + 32'd4;
                    words++;
                    test_words++;
                end
            end
            if (enable_i) begin
                stall_reqs = 0;
            end else if (imem_req_i.en && !busy_i) begin
                stall_reqs++;   // each reply needs its own queue entry.
                if (stall_reqs == `FETCH_IQ_DEPTH + 1)
                    failure("memory requests went on during a decode stall with the queue full");
            end
            hold_armed     = 1'b0;
            after_restart  = 1'b0;
            after_redirect = 1'b0;
            if (sys_reset_i) begin
                expected_pc   = `FETCH_START_ADDR;
                after_restart = 1'b1;
                stall_reqs    = 0;
                stale_words   = 0;
            end else if (redirect_i.jump || redirect_i.ctx_switch) begin
                expected_pc    = redirect_i.ctx_switch ? redirect_i.ctx_target
                                                       : redirect_i.jump_target;
                after_redirect = 1'b1;
                stall_reqs     = 0;
                stale_words    = 0;
            end else if (!enable_i && !jumping_i) begin
                held       = fetch_i;
                hold_armed = 1'b1;
            end
            if (test_done_i)
                report_test();
        end
    end

endmodule

// File: bench/fetch_tb.sv
/*
 * testbench of the instruction fetch stage. replays bench/fetch_vectors.txt
 * one test per line, models the instruction memory and leaves all comparing
 * to fetch_checker. a cycle counter ends a run that never finishes.
 */
`include "fetch_defines.svh"

module fetch_tb
    import fetch_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_TESTS    = 32;
    localparam int FIELDS       = 6;   // columns of one vector line.
    localparam int RESET_CYCLES = 4;

    logic        clk;
    logic        reset_n;
    logic        sys_reset;
    logic        enable;
    logic        busy;
    redirect_t   redirect;
    imem_req_t   imem_req;
    word_t       imem_data = '0;
    fetch_out_t  fetch_out;
    logic        jumping;
    logic [31:0] vec_mem [MAX_TESTS*FIELDS];
    logic [15:0] lfsr;
    logic        test_done;
    int          test_id;
    int          test_count;
    int          setup_errors;
    int          cycle_limit = 0;   // zero until the vectors are read.
    int          cycle_count = 0;
    int          errors;
    int          failed_tests;
    int          words;

    fetch_top dut (
        .clk        (clk),
        .reset_n    (reset_n),
        .sys_reset_i(sys_reset),
        .enable_i   (enable),
        .redirect_i (redirect),
        .imem_req_o (imem_req),
        .busy_i     (busy),
        .imem_data_i(imem_data),
        .fetch_o    (fetch_out),
        .jumping_o  (jumping)
    );

    fetch_checker u_checker (
        .clk           (clk),
        .reset_n       (reset_n),
        .sys_reset_i   (sys_reset),
        .enable_i      (enable),
        .busy_i        (busy),
        .redirect_i    (redirect),
        .imem_req_i    (imem_req),
        .fetch_i       (fetch_out),
        .jumping_i     (jumping),
        .test_id_i     (test_id),
        .test_done_i   (test_done),
        .errors_o      (errors),
        .failed_tests_o(failed_tests),
        .words_o       (words)
    );

    // an accepted request is answered with its address under an A5 top byte.
    function automatic word_t mem_word(input word_t addr);
        return {8'hA5, addr[23:0]};
    endfunction

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic [15:0] shifted;
        shifted = state >> 1;
        if (state[0])
            shifted = shifted ^ 16'hB400;   // taps at 16, 14, 13 and 11.
        return shifted;
    endfunction

    // four bits, one step each, give a value from 0 to 15.
    task automatic draw_nibble(output int value);
        value = 0;
        for (int i = 0; i < 4; i++) begin
            value = value * 2 + int'(lfsr[0]);
            lfsr  = lfsr_next(lfsr);
        end
    endtask

    task automatic clear_strobes();
        redirect.jump       = 1'b0;
        redirect.ctx_switch = 1'b0;
        sys_reset           = 1'b0;
    endtask

    // the field that must not win gets a decoy target.
    task automatic apply_event(input int kind, input word_t target);
        redirect.jump_target = target;
        redirect.ctx_target  = target;
        case (kind)
            1: begin
                redirect.jump       = 1'b1;
                redirect.ctx_target = target + 32'h0001_0000;
            end
            2, 3: begin
                redirect.ctx_switch  = 1'b1;
                redirect.jump        = (kind == 3);
                redirect.jump_target = target + 32'h0001_0000;
            end
            4: sys_reset = 1'b1;
            default: ;
        endcase
    endtask

    task automatic run_test(input int t);
        int    cycles;
        int    en_den;
        int    busy_den;
        int    event_cycle;
        int    kind;
        int    draw;
        word_t target;
        cycles      = int'(vec_mem[t*FIELDS]);
        en_den      = int'(vec_mem[t*FIELDS+1]);
        busy_den    = int'(vec_mem[t*FIELDS+2]);
        event_cycle = int'(vec_mem[t*FIELDS+3]);
        kind        = int'(vec_mem[t*FIELDS+4]);
        target      = vec_mem[t*FIELDS+5];
        for (int c = 0; c < cycles; c++) begin
            @(negedge clk);
            test_done = 1'b0;   // the previous test is reported by now.
            test_id   = t + 1;
            draw_nibble(draw);
            enable = (draw < en_den);
            draw_nibble(draw);
            busy = (draw < busy_den);
            clear_strobes();
            if (c == event_cycle)
                apply_event(kind, target);
        end
        // drain until a word after the last redirect or restart is shown.
        while (!test_done) begin
            @(negedge clk);
            enable = 1'b1;
            busy   = 1'b0;
            clear_strobes();
            test_done = !jumping && fetch_out.valid;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        if (imem_req.en && !busy)
            imem_data <= mem_word(imem_req.addr);
        else
            imem_data <= 32'hDEAD_BEEF;   // no reply is owed this cycle.
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, the vectors did not finish", cycle_count);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        reset_n      = 1'b0;
        enable       = 1'b0;
        busy         = 1'b0;
        redirect     = '0;
        sys_reset    = 1'b0;
        test_done    = 1'b0;
        test_id      = 0;
        setup_errors = 0;
        lfsr         = 16'd54;
        for (int i = 0; i < MAX_TESTS * FIELDS; i++)
            vec_mem[i] = '0;
        $readmemh("bench/fetch_vectors.txt", vec_mem);
        test_count = 0;
        while (test_count < MAX_TESTS && vec_mem[test_count*FIELDS] != 0)
            test_count++;
        if (test_count == 0) begin
            $display("no test vectors were read from bench/fetch_vectors.txt");
            setup_errors = 1;
        end
        cycle_limit = RESET_CYCLES;   // each test gets its own length plus 20.
        for (int t = 0; t < test_count; t++)
            cycle_limit = cycle_limit + int'(vec_mem[t*FIELDS]) + 20;
        repeat (RESET_CYCLES) @(negedge clk);
        reset_n = 1'b1;
        for (int t = 0; t < test_count; t++)
            run_test(t);
        @(negedge clk);
        test_done = 1'b0;
        @(negedge clk);
        $display("tests %0d, failed %0d, words checked %0d, errors %0d",
                 test_count, failed_tests, words, errors + setup_errors);
        if (errors == 0 && failed_tests == 0 && setup_errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// File: files.f
+incdir+hdl
hdl/fetch_pkg.sv
hdl/instr_queue.sv
hdl/fetch_request.sv
hdl/fetch_output.sv
hdl/fetch_top.sv
bench/fetch_checker.sv
bench/fetch_tb.sv

// File: run.sh
#!/bin/sh
# builds the fetch stage testbench with Verilator, runs it and looks for the pass line.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/100ps \
    --top-module fetch_tb \
    -f files.f

output=$(./obj_dir/Vfetch_tb)
echo "$output"

if echo "$output" | grep -qF '** PASS **'; then
    exit 0
fi
exit 1

// File: bench/fetch_vectors.txt
// fetch stage test vectors, one test per line, every field in hex.
// cycles  enable_per_16  busy_per_16  event_cycle  kind  target
// kind 0 none, 1 jump, 2 context switch, 3 jump and context switch together,
// 4 sys_reset. event_cycle ffff means the test has no event.
// stream right after reset, decode always ready and an idle memory.
20 10 00 ffff 0 00000000
// random decode stalls and memory busy cycles.
60 0b 05 ffff 0 00000000
// long decode stall, then the stream resumes.
30 00 03 ffff 0 00000000
40 0c 04 ffff 0 00000000
// plain jumps, first with an idle memory, then under load.
30 10 00 0006 1 00002000
40 09 06 000a 1 00003100
// both strobes at once, the context switch wins.
30 10 03 0005 3 00005000
30 08 04 0008 2 00006040
// synchronous restart in the middle of a stream.
40 0c 04 000c 4 00000000
// jump while decode is stalled the whole time.
40 00 00 0003 1 00007000
50 0a 08 0014 3 00008ab0
60 0d 03 ffff 0 00000000
// heavy busy around a jump, then a restart with slow decode.
28 10 0c 0002 1 0000a000
40 05 0a 0020 4 00000000
// end of the list.
0 0 0 0 0 0
